/* Bender.yml */
package:
  name: exec_ctl

sources:
  - files:
      - hw/exec_ctl_pkg.sv
      - hw/instr_decoder.sv
      - hw/ctl_stage_reg.sv
      - hw/branch_resolver.sv
      - hw/exec_ctl_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/exec_ctl_tb.sv

/* build.f */
+incdir+verif
hw/exec_ctl_pkg.sv
hw/instr_decoder.sv
hw/ctl_stage_reg.sv
hw/branch_resolver.sv
hw/exec_ctl_top.sv
verif/exec_ctl_tb.sv

/* hw/branch_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolver
    import exec_ctl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  br_kind_t br_kind,
    input  logic     br_eq,
    input  logic     br_lt,
    output logic     pc_sel
);

    // Comparator flags belong to the instruction held in execute
    always_comb begin
        case (br_kind)
            br_jump:            pc_sel = 1'b1;
            exec_ctl_pkg::br_eq: pc_sel = br_eq;
            br_ne:              pc_sel = !br_eq;
            exec_ctl_pkg::br_lt: pc_sel = br_lt;
            br_ge:              pc_sel = !br_lt;
            default:            pc_sel = 1'b0;
        endcase
    end

    // No redirect without a branch or jump in the stage
    a_none_no_redirect: assert property (
        @(posedge clk) disable iff (rst)
        (br_kind == br_none) |-> !pc_sel
    ) else $error("branch_resolver: pc_sel high with no branch");

endmodule

`default_nettype wire

/* hw/ctl_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ctl_stage_reg
    import exec_ctl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  stage_ctl_t decoded,
    input  instr_t     instruction,
    output stage_ctl_t stage,
    output instr_t     instr_acc
);

    // Execute-stage state, one new instruction per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            stage     <= ctl_reset;
            instr_acc <= '0;
        end else begin
            stage     <= decoded;
            instr_acc <= instruction;
        end
    end

    // Registered kind must come from a legal decode
    a_kind_legal: assert property (
        @(posedge clk) disable iff (rst)
        stage.br_kind inside {br_none, br_jump, br_eq, br_ne, br_lt, br_ge}
    ) else $error("ctl_stage_reg: illegal branch kind %0d", stage.br_kind);

    // Unsigned compare only for ordered branches
    a_br_un_kind: assert property (
        @(posedge clk) disable iff (rst)
        stage.ctl.br_un |-> stage.br_kind inside {br_lt, br_ge}
    ) else $error("ctl_stage_reg: br_un set for kind %0d", stage.br_kind);

endmodule

`default_nettype wire

/* hw/exec_ctl_pkg.sv */
`default_nettype none

package exec_ctl_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] instr_t;

    // Field view of an R/I-type word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // Alternate funct7 selects SUB and the arithmetic shifts
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    typedef enum logic [3:0] {
        alu_and    = 4'b0000,
        alu_or     = 4'b0001,
        alu_xor    = 4'b0010,
        alu_add    = 4'b0011,
        alu_sub    = 4'b0100,
        alu_pass_b = 4'b0110,
        alu_sll    = 4'b0111,
        alu_srl    = 4'b1000,
        alu_sra    = 4'b1010,
        alu_sltu   = 4'b1011,
        alu_slt    = 4'b1100
    } alu_op_t;

    // How the next-PC select is resolved in execute
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_jump = 3'd1,
        br_eq   = 3'd2,
        br_ne   = 3'd3,
        br_lt   = 3'd4,
        br_ge   = 3'd5
    } br_kind_t;

    // Datapath controls of one instruction
    typedef struct packed {
        logic    a_sel;
        logic    b_sel;
        alu_op_t alu_sel;
        logic    sign;
        logic    br_un;
    } ex_ctl_t;

    typedef struct packed {
        ex_ctl_t  ctl;
        br_kind_t br_kind;
    } stage_ctl_t;

    // Stage contents while in reset
    localparam stage_ctl_t ctl_reset = '{
        ctl: '{a_sel: 1'b0, b_sel: 1'b1, alu_sel: alu_pass_b, sign: 1'b0, br_un: 1'b0},
        br_kind: br_none
    };

    // Unknown encodings
    localparam stage_ctl_t ctl_default = '{
        ctl: '{a_sel: 1'b0, b_sel: 1'b0, alu_sel: alu_and, sign: 1'b0, br_un: 1'b0},
        br_kind: br_none
    };

endpackage

`default_nettype wire

/* hw/exec_ctl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctl_top
    import exec_ctl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  instr_t  instruction,
    input  logic    br_eq,
    input  logic    br_lt,
    output ex_ctl_t ctl,
    output logic    pc_sel,
    output instr_t  instr_acc
);

    stage_ctl_t decoded;
    stage_ctl_t stage;

    instr_decoder u_decoder (
        .instruction (instruction),
        .decoded     (decoded)
    );

    ctl_stage_reg u_stage (
        .clk         (clk),
        .rst         (rst),
        .decoded     (decoded),
        .instruction (instruction),
        .stage       (stage),
        .instr_acc   (instr_acc)
    );

    // Resolved from the registered kind
    branch_resolver u_resolver (
        .clk     (clk),
        .rst     (rst),
        .br_kind (stage.br_kind),
        .br_eq   (br_eq),
        .br_lt   (br_lt),
        .pc_sel  (pc_sel)
    );

    assign ctl = stage.ctl;

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import exec_ctl_pkg::*;
(
    input  instr_t     instruction,
    output stage_ctl_t decoded
);

    instr_fields_t f;
    logic          imm_alt;
    logic          imm_ok;
    logic          reg_alt;
    logic          reg_ok;

    // funct3 to ALU op, shared by OP-IMM and OP
    function automatic alu_op_t funct3_alu(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign f = instr_fields_t'(instruction);

    // Only SRAI may use the alternate funct7 in OP-IMM
    assign imm_alt = (f.funct3 == 3'b101) && (f.funct7 == f7_alt);

    always_comb begin
        case (f.funct3)
            3'b001:  imm_ok = (f.funct7 == f7_base);
            3'b101:  imm_ok = (f.funct7 == f7_base) || imm_alt;
            default: imm_ok = 1'b1;
        endcase
    end

    // SUB and SRA are the only alternates in OP
    assign reg_alt = (f.funct7 == f7_alt);
    assign reg_ok  = (f.funct7 == f7_base) || (reg_alt && f.funct3 inside {3'b000, 3'b101});

    always_comb begin
        decoded = ctl_default;
        case (f.opcode)
            op_lui: begin
                decoded.ctl.b_sel   = 1'b1;
                decoded.ctl.alu_sel = alu_pass_b;
            end
            op_auipc: begin
                decoded.ctl.a_sel   = 1'b1;
                decoded.ctl.b_sel   = 1'b1;
                decoded.ctl.alu_sel = alu_add;
            end
            op_jal: begin
                decoded.ctl.a_sel   = 1'b1;
                decoded.ctl.b_sel   = 1'b1;
                decoded.ctl.alu_sel = alu_add;
                decoded.ctl.sign    = 1'b1;
                decoded.br_kind     = br_jump;
            end
            op_jalr: begin
                if (f.funct3 == 3'b000) begin
                    decoded.ctl.b_sel   = 1'b1;
                    decoded.ctl.alu_sel = alu_add;
                    decoded.ctl.sign    = 1'b1;
                    decoded.br_kind     = br_jump;
                end
            end
            op_branch: begin
                case (f.funct3)
                    3'b000:         decoded.br_kind = br_eq;
                    3'b001:         decoded.br_kind = br_ne;
                    3'b100, 3'b110: decoded.br_kind = br_lt;
                    3'b101, 3'b111: decoded.br_kind = br_ge;
                    default:        decoded.br_kind = br_none;
                endcase
                // funct3 bit 1 marks the unsigned compares
                if (decoded.br_kind != br_none) begin
                    decoded.ctl.alu_sel = alu_add;
                    decoded.ctl.br_un   = f.funct3[1];
                end
            end
            op_load: begin
                if (f.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    decoded.ctl.b_sel   = 1'b1;
                    decoded.ctl.alu_sel = alu_add;
                    decoded.ctl.sign    = !f.funct3[2];
                end
            end
            op_store: begin
                if (f.funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    decoded.ctl.b_sel   = 1'b1;
                    decoded.ctl.alu_sel = alu_add;
                    decoded.ctl.sign    = 1'b1;
                end
            end
            op_imm: begin
                if (imm_ok) begin
                    decoded.ctl.b_sel   = 1'b1;
                    decoded.ctl.alu_sel = funct3_alu(f.funct3, imm_alt);
                    // Sign-extended immediate for ADDI and the logic ops
                    decoded.ctl.sign    = f.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
                end
            end
            op_reg: begin
                if (reg_ok) begin
                    decoded.ctl.alu_sel = funct3_alu(f.funct3, reg_alt);
                end
            end
            default: decoded = ctl_default;
        endcase
    end

    always_comb begin
        a_alu_named: assert (decoded.ctl.alu_sel inside {alu_and, alu_or, alu_xor, alu_add,
                alu_sub, alu_pass_b, alu_sll, alu_srl, alu_sra, alu_sltu, alu_slt})
            else $error("instr_decoder: unnamed ALU code %b", decoded.ctl.alu_sel);
    end

endmodule

`default_nettype wire

/* verif/exec_ctl_ref.svh */
`ifndef EXEC_CTL_REF_SVH
`define EXEC_CTL_REF_SVH

// Build one expected control bundle
function automatic stage_ctl_t make_ctl(
    input logic     a_sel,
    input logic     b_sel,
    input alu_op_t  alu_sel,
    input logic     sign,
    input logic     br_un,
    input br_kind_t kind
);
    stage_ctl_t r;
    r.ctl.a_sel   = a_sel;
    r.ctl.b_sel   = b_sel;
    r.ctl.alu_sel = alu_sel;
    r.ctl.sign    = sign;
    r.ctl.br_un   = br_un;
    r.br_kind     = kind;
    return r;
endfunction

// Expected decode, one entry per kept mnemonic
function automatic stage_ctl_t ref_decode(input instr_t w);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    stage_ctl_t r;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    r   = ctl_default;
    case (opc)
        op_lui:   r = make_ctl(1'b0, 1'b1, alu_pass_b, 1'b0, 1'b0, br_none);
        op_auipc: r = make_ctl(1'b1, 1'b1, alu_add, 1'b0, 1'b0, br_none);
        op_jal:   r = make_ctl(1'b1, 1'b1, alu_add, 1'b1, 1'b0, br_jump);
        op_jalr: begin
            if (f3 == 3'b000)
                r = make_ctl(1'b0, 1'b1, alu_add, 1'b1, 1'b0, br_jump);
        end
        op_branch: begin
            case (f3)
                3'b000:  r = make_ctl(1'b0, 1'b0, alu_add, 1'b0, 1'b0, br_eq);
                3'b001:  r = make_ctl(1'b0, 1'b0, alu_add, 1'b0, 1'b0, br_ne);
                3'b100:  r = make_ctl(1'b0, 1'b0, alu_add, 1'b0, 1'b0, br_lt);
                3'b101:  r = make_ctl(1'b0, 1'b0, alu_add, 1'b0, 1'b0, br_ge);
                3'b110:  r = make_ctl(1'b0, 1'b0, alu_add, 1'b0, 1'b1, br_lt);
                3'b111:  r = make_ctl(1'b0, 1'b0, alu_add, 1'b0, 1'b1, br_ge);
                default: r = ctl_default;
            endcase
        end
        op_load: begin
            case (f3)
                3'b000, 3'b001, 3'b010: r = make_ctl(1'b0, 1'b1, alu_add, 1'b1, 1'b0, br_none);
                3'b100, 3'b101:         r = make_ctl(1'b0, 1'b1, alu_add, 1'b0, 1'b0, br_none);
                default:                r = ctl_default;
            endcase
        end
        op_store: begin
            if (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b010)
                r = make_ctl(1'b0, 1'b1, alu_add, 1'b1, 1'b0, br_none);
        end
        op_imm: begin
            case (f3)
                3'b000: r = make_ctl(1'b0, 1'b1, alu_add, 1'b1, 1'b0, br_none);
                3'b010: r = make_ctl(1'b0, 1'b1, alu_slt, 1'b0, 1'b0, br_none);
                3'b011: r = make_ctl(1'b0, 1'b1, alu_sltu, 1'b0, 1'b0, br_none);
                3'b100: r = make_ctl(1'b0, 1'b1, alu_xor, 1'b1, 1'b0, br_none);
                3'b110: r = make_ctl(1'b0, 1'b1, alu_or, 1'b1, 1'b0, br_none);
                3'b111: r = make_ctl(1'b0, 1'b1, alu_and, 1'b1, 1'b0, br_none);
                3'b001: begin
                    if (f7 == f7_base)
                        r = make_ctl(1'b0, 1'b1, alu_sll, 1'b0, 1'b0, br_none);
                end
                default: begin
                    if (f7 == f7_base)
                        r = make_ctl(1'b0, 1'b1, alu_srl, 1'b0, 1'b0, br_none);
                    else if (f7 == f7_alt)
                        r = make_ctl(1'b0, 1'b1, alu_sra, 1'b0, 1'b0, br_none);
                end
            endcase
        end
        op_reg: begin
            case ({f7, f3})
                {f7_base, 3'b000}: r = make_ctl(1'b0, 1'b0, alu_add, 1'b0, 1'b0, br_none);
                {f7_alt, 3'b000}:  r = make_ctl(1'b0, 1'b0, alu_sub, 1'b0, 1'b0, br_none);
                {f7_base, 3'b001}: r = make_ctl(1'b0, 1'b0, alu_sll, 1'b0, 1'b0, br_none);
                {f7_base, 3'b010}: r = make_ctl(1'b0, 1'b0, alu_slt, 1'b0, 1'b0, br_none);
                {f7_base, 3'b011}: r = make_ctl(1'b0, 1'b0, alu_sltu, 1'b0, 1'b0, br_none);
                {f7_base, 3'b100}: r = make_ctl(1'b0, 1'b0, alu_xor, 1'b0, 1'b0, br_none);
                {f7_base, 3'b101}: r = make_ctl(1'b0, 1'b0, alu_srl, 1'b0, 1'b0, br_none);
                {f7_alt, 3'b101}:  r = make_ctl(1'b0, 1'b0, alu_sra, 1'b0, 1'b0, br_none);
                {f7_base, 3'b110}: r = make_ctl(1'b0, 1'b0, alu_or, 1'b0, 1'b0, br_none);
                {f7_base, 3'b111}: r = make_ctl(1'b0, 1'b0, alu_and, 1'b0, 1'b0, br_none);
                default:           r = ctl_default;
            endcase
        end
        default: r = ctl_default;
    endcase
    return r;
endfunction

// Expected next-PC select for the kind held in execute
function automatic logic ref_pc_sel(input br_kind_t kind, input logic eq, input logic lt);
    case (kind)
        br_jump: return 1'b1;
        br_eq:   return eq;
        br_ne:   return !eq;
        br_lt:   return lt;
        br_ge:   return !lt;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

/* verif/exec_ctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctl_tb
    import exec_ctl_pkg::*;
();

    logic        clk;
    logic        rst;
    instr_t      instruction;
    logic        flag_eq;
    logic        flag_lt;
    ex_ctl_t     ctl;
    logic        pc_sel;
    instr_t      instr_acc;

    int unsigned edge_count = 0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;
    int unsigned test_count = 0;
    int unsigned failed_tests = 0;
    int unsigned test_checks0;
    int unsigned test_errors0;
    string       cur_test = "none";
    logic [31:0] rng_state;

    `include "exec_ctl_ref.svh"

    exec_ctl_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .br_eq       (flag_eq),
        .br_lt       (flag_lt),
        .ctl         (ctl),
        .pc_sel      (pc_sel),
        .instr_acc   (instr_acc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    function automatic instr_t encode_word(
        input logic [6:0] f7,
        input logic [2:0] f3,
        input logic [6:0] opc
    );
        return {f7, 5'd3, 5'd2, f3, 5'd1, opc};
    endfunction

    // Returns one step after the edge, since edge_count moves in the NBA region
    task automatic wait_rise();
        int unsigned start;
        int          guard;
        start = edge_count;
        guard = 0;
        while (edge_count == start && guard < 30) begin
            #1;
            guard++;
        end
        if (edge_count == start) begin
            $display("Timeout: no rising clock edge within 30 ns");
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic drive(input instr_t w, input logic eq, input logic lt);
        wait_rise();
        #1;
        instruction = w;
        flag_eq     = eq;
        flag_lt     = lt;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
        error_count++;
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        test_checks0 = check_count;
        test_errors0 = error_count;
    endtask

    // Lets the last driven word reach its check
    task automatic finish_test();
        int unsigned errs;
        wait_rise();
        #5;
        errs = error_count - test_errors0;
        test_count++;
        if (errs != 0)
            failed_tests++;
        $display("%s: %0d checks, %0d errors", cur_test, check_count - test_checks0, errs);
    endtask

    // Output comparison, 5 ns after every rising edge
    initial begin
        instr_t     in_instr;
        logic       in_rst;
        stage_ctl_t exp_stage;
        instr_t     exp_acc;
        logic       exp_pc;
        forever begin
            wait_rise();
            in_instr = instruction;
            in_rst   = rst;
            #4;
            exp_stage = in_rst ? ctl_reset : ref_decode(in_instr);
            exp_acc   = in_rst ? '0 : in_instr;
            exp_pc    = ref_pc_sel(exp_stage.br_kind, flag_eq, flag_lt);
            check_count += 3;
            a_ctl: assert (ctl === exp_stage.ctl)
                else report_mismatch("ctl", 32'(exp_stage.ctl), 32'(ctl));
            a_acc: assert (instr_acc === exp_acc)
                else report_mismatch("instr_acc", exp_acc, instr_acc);
            a_pc: assert (pc_sel === exp_pc)
                else report_mismatch("pc_sel", 32'(exp_pc), 32'(pc_sel));
        end
    end

    initial begin
        instr_t     dir_words [0:36];
        instr_t     br_words [0:7];
        instr_t     bad_words [0:8];
        logic [6:0] kept_ops [0:8];
        instr_t     word;
        int unsigned pick;

        rst         = 1'b1;
        instruction = encode_word(7'h07, 3'b110, op_jal);
        flag_eq     = 1'b0;
        flag_lt     = 1'b0;
        rng_state   = 32'd43;

        dir_words = '{
            encode_word(7'h12, 3'b101, op_lui), encode_word(7'h34, 3'b010, op_auipc),
            encode_word(7'h07, 3'b110, op_jal), encode_word(7'h01, 3'b000, op_jalr),
            encode_word(7'h00, 3'b000, op_branch), encode_word(7'h00, 3'b001, op_branch),
            encode_word(7'h00, 3'b100, op_branch), encode_word(7'h00, 3'b101, op_branch),
            encode_word(7'h00, 3'b110, op_branch), encode_word(7'h00, 3'b111, op_branch),
            encode_word(7'h02, 3'b000, op_load), encode_word(7'h02, 3'b001, op_load),
            encode_word(7'h02, 3'b010, op_load), encode_word(7'h02, 3'b100, op_load),
            encode_word(7'h02, 3'b101, op_load), encode_word(7'h04, 3'b000, op_store),
            encode_word(7'h04, 3'b001, op_store), encode_word(7'h04, 3'b010, op_store),
            encode_word(7'h7f, 3'b000, op_imm), encode_word(7'h05, 3'b010, op_imm),
            encode_word(7'h05, 3'b011, op_imm), encode_word(7'h05, 3'b100, op_imm),
            encode_word(7'h05, 3'b110, op_imm), encode_word(7'h05, 3'b111, op_imm),
            encode_word(f7_base, 3'b001, op_imm), encode_word(f7_base, 3'b101, op_imm),
            encode_word(f7_alt, 3'b101, op_imm), encode_word(f7_base, 3'b000, op_reg),
            encode_word(f7_alt, 3'b000, op_reg), encode_word(f7_base, 3'b001, op_reg),
            encode_word(f7_base, 3'b010, op_reg), encode_word(f7_base, 3'b011, op_reg),
            encode_word(f7_base, 3'b100, op_reg), encode_word(f7_base, 3'b101, op_reg),
            encode_word(f7_alt, 3'b101, op_reg), encode_word(f7_base, 3'b110, op_reg),
            encode_word(f7_base, 3'b111, op_reg)
        };
        br_words = '{
            dir_words[4], dir_words[5], dir_words[6], dir_words[7],
            dir_words[8], dir_words[9], dir_words[2], dir_words[27]
        };
        bad_words = '{
            encode_word(7'h00, 3'b000, 7'b0001111), encode_word(7'h00, 3'b000, 7'b1110011),
            encode_word(7'h00, 3'b000, 7'b0000000), encode_word(7'h7f, 3'b111, 7'b1111111),
            encode_word(7'h00, 3'b010, op_branch), encode_word(7'h00, 3'b011, op_branch),
            encode_word(7'h01, 3'b000, op_reg), encode_word(f7_alt, 3'b001, op_reg),
            encode_word(7'h00, 3'b001, op_jalr)
        };
        kept_ops = '{op_lui, op_auipc, op_jal, op_jalr, op_branch,
                     op_load, op_store, op_imm, op_reg};

        // Reset holds for 8 edges while a live JAL sits on the input
        start_test("reset");
        repeat (8) wait_rise();
        #1;
        rst = 1'b0;
        finish_test();

        start_test("directed_decode");
        for (int i = 0; i < 37; i++)
            drive(dir_words[i], 1'b0, 1'b0);
        finish_test();

        start_test("branch_resolution");
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++)
                drive(br_words[i], k[0], k[1]);
        end
        finish_test();

        start_test("unknown_encodings");
        for (int i = 0; i < 9; i++)
            drive(bad_words[i], i[0], !i[0]);
        finish_test();

        start_test("random_stream");
        for (int n = 0; n < 500; n++) begin
            rng_state = xorshift32(rng_state);
            pick      = rng_state % 9;
            rng_state = xorshift32(rng_state);
            word      = rng_state;
            word[6:0] = kept_ops[pick];
            // Bias OP and OP-IMM towards legal funct7 values
            if ((word[6:0] == op_reg || word[6:0] == op_imm) && word[7])
                word[31:25] = word[8] ? f7_alt : f7_base;
            rng_state = xorshift32(rng_state);
            drive(word, rng_state[3], rng_state[11]);
        end
        finish_test();

        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
